/* all.f */
+incdir+src
src/drive_cmd_pkg.sv
src/cmd_message_rom.sv
src/frame_sequencer.sv
src/uart_tx.sv
src/json_uart_top.sv
testbench/tb_json_uart.sv

/* testbench/tb_json_uart.sv */
`timescale 1ns/100ps

module tb_json_uart
    import drive_cmd_pkg::*;
();

    localparam int CPB     = 8;   // Clocks per serial bit
    localparam int GAP     = 5;   // Idle clocks before a message
    localparam int N_MSG   = 20;  // Reset message, 7 held codes, 6 pairs with a change
    localparam int WD_CLKS = N_MSG * 27 * (10 * CPB + 2) + N_MSG * 100 + 1000;

    logic        clk;
    logic        rst;
    logic [2:0]  mode_sel;
    logic        uart_txd;
    logic [17:0] leds;
    logic        done;

    logic [31:0] lfsr;
    int          errors = 0;
    int          msgs_checked = 0;
    int          latch_cnt = 0;   // Clocks until the DUT takes mode_sel
    logic [2:0]  mode_q[$];       // Code applied at each message start
    logic [7:0]  rx_q[$];         // Bytes of the message on the line

    json_uart_top #(
        .CLKS_PER_BIT (CPB),
        .GAP_CYCLES   (GAP)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .mode_sel (mode_sel),
        .uart_txd (uart_txd),
        .leds     (leds),
        .done     (done)
    );

    always #10 clk = ~clk;

    // Switch code to drive command, spare codes mean stop
    function automatic drive_mode_t code_to_mode(input logic [2:0] code);
        case (code)
            3'd1:    return MODE_LEFT;
            3'd2:    return MODE_RIGHT;
            3'd3:    return MODE_FAST;
            3'd4:    return MODE_SLOW;
            default: return MODE_STOP;
        endcase
    endfunction

    // Wheel speed fields of each command
    function automatic string left_speed(input drive_mode_t m);
        case (m)
            MODE_LEFT:  return "-0.25";
            MODE_RIGHT: return "0.25";
            MODE_FAST:  return "0.5";
            MODE_SLOW:  return "0.25";
            default:    return "0";
        endcase
    endfunction

    function automatic string right_speed(input drive_mode_t m);
        case (m)
            MODE_LEFT:  return "0.25";
            MODE_RIGHT: return "-0.25";
            MODE_FAST:  return "0.5";
            MODE_SLOW:  return "0.25";
            default:    return "0";
        endcase
    endfunction

    function automatic string expected_text(input drive_mode_t m);
        return $sformatf("{\"T\":1,\"L\":%s,\"R\":%s}\n", left_speed(m), right_speed(m));
    endfunction

    function automatic int expected_len(input drive_mode_t m);
        string txt;
        txt = expected_text(m);
        return txt.len();
    endfunction

    function automatic logic [7:0] expected_byte(input drive_mode_t m, input int idx);
        string txt;
        txt = expected_text(m);
        if (idx < txt.len()) begin
            return txt[idx];
        end else begin
            return 8'h0A;  // Past the end
        end
    endfunction

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] st);
        if (st[0]) begin
            return (st >> 1) ^ 32'h8020_0003;
        end else begin
            return st >> 1;
        end
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s exp=%h got=%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s exp=%h got=%h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_mode_len(input drive_mode_t exp_m, input drive_mode_t got_m,
                                  input int exp_len, input int got_len);
        if (got_m !== exp_m) begin
            errors++;
            $display("[FAIL] msg_mode exp=%h got=%h at %0t", exp_m, got_m, $time);
        end
        if (got_len != exp_len) begin
            errors++;
            $display("[FAIL] msg_len exp=%h got=%h at %0t", exp_len, got_len, $time);
        end
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (done !== 1'b1);
    endtask

    task automatic drive_mode(input logic [2:0] code);
        @(posedge clk);
        #2 mode_sel = code;
    endtask

    // Mode is taken GAP+1 clocks after done, or after reset
    always @(negedge clk) begin
        if (latch_cnt > 0) begin
            latch_cnt = latch_cnt - 1;
            if (latch_cnt == 0) begin
                mode_q.push_back(mode_sel);
            end
        end
        if (rst || done) begin
            latch_cnt = GAP + 1;
        end
    end

    // Serial decoder, one sample per clock on the falling edge
    initial begin : line_decoder
        logic       smp [10*CPB];
        logic       prev;
        logic       held_ok;
        logic [7:0] rx;
        int         i;
        int         b;
        int         c;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (!rst && prev && !uart_txd) begin  // Falling start edge
                smp[0] = uart_txd;
                for (i = 1; i < 10 * CPB; i++) begin
                    @(negedge clk);
                    smp[i] = uart_txd;
                end
                held_ok = 1'b1;
                for (b = 0; b < 10; b++) begin
                    for (c = 1; c < CPB; c++) begin
                        if (smp[b*CPB + c] !== smp[b*CPB]) begin
                            held_ok = 1'b0;
                        end
                    end
                end
                if (!held_ok) begin
                    errors++;
                    $display("line level changed inside a bit period, frame ending %0t", $time);
                end
                check_bit("start bit", 1'b0, smp[CPB/2]);
                check_bit("stop bit", 1'b1, smp[9*CPB + CPB/2]);
                for (b = 0; b < 8; b++) begin
                    rx[b] = smp[(b+1)*CPB + CPB/2];  // LSB first, mid bit
                end
                rx_q.push_back(rx);
            end
            prev = uart_txd;
        end
    end

    // Whole message compared at each done
    initial begin : message_compare
        drive_mode_t m;
        int          len;
        int          i;
        forever begin
            @(negedge clk);
            if (!rst && done) begin
                if (mode_q.size() == 0) begin
                    errors++;
                    $display("done pulsed with no message start recorded at %0t", $time);
                    m = MODE_STOP;
                end else begin
                    m = code_to_mode(mode_q.pop_front());
                end
                len = expected_len(m);
                check_mode_len(m, dut0.u_seq.msg_mode, len, rx_q.size());
                for (i = 0; i < rx_q.size() && i < len; i++) begin
                    check_byte($sformatf("uart byte %0d", i), expected_byte(m, i), rx_q[i]);
                end
                rx_q.delete();
                msgs_checked++;
                @(negedge clk);  // Sticky bit lands one clock after done
                check_byte("leds[7:0]", 8'h0A, leds[7:0]);
                check_bit("leds[17]", 1'b1, leds[17]);
            end
        end
    end

    initial begin : stimulus
        int a;
        int b;
        int wait_clks;
        clk      = 1'b0;
        rst      = 1'b1;
        mode_sel = 3'd0;
        lfsr     = 32'he636_c301;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        check_bit("uart_txd", 1'b1, uart_txd);
        check_bit("done", 1'b0, done);
        check_byte("leds[7:0]", 8'h00, leds[7:0]);
        check_byte("leds[15:8]", 8'h00, leds[15:8]);
        check_bit("leds[16]", 1'b0, leds[16]);
        check_bit("leds[17]", 1'b0, leds[17]);

        wait_done();  // Stop message out of reset

        // Each code held for one message, 5..7 give stop
        for (a = 1; a < 8; a++) begin
            drive_mode(a[2:0]);
            wait_done();
        end

        // Code change while a message is on the line
        repeat (6) begin
            take_bits(3, a);
            take_bits(3, b);
            take_bits(10, wait_clks);
            drive_mode(a[2:0]);
            repeat (GAP + 3 + wait_clks) @(posedge clk);
            #2 mode_sel = b[2:0];
            wait_done();
            wait_done();
        end

        repeat (3) @(negedge clk);
        if (msgs_checked != N_MSG) begin
            errors++;
            $display("only %0d of %0d messages were checked", msgs_checked, N_MSG);
        end
        $display("%0d messages checked, %0d errors", msgs_checked, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WD_CLKS) @(posedge clk);
        $display("timeout, messages stopped arriving after %0d clocks", WD_CLKS);
        $display("sim failed");
        $finish;
    end

endmodule

/* src/json_uart_top.sv */
`timescale 1ns/100ps

`include "drive_cmd_macros.svh"

module json_uart_top
    import drive_cmd_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DRV_CLKS_PER_BIT,
    parameter int GAP_CYCLES   = `DRV_GAP_CYCLES
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  mode_sel,   // Drive command switches
    output logic        uart_txd,
    output logic [17:0] leds,
    output logic        done        // One pulse per message
);

    drive_mode_t              msg_mode;
    logic [`DRV_IDX_W-1:0]    byte_idx;
    logic [`DRV_IDX_W-1:0]    msg_len;
    logic [7:0]               msg_byte;
    logic [7:0]               tx_data;
    logic                     tx_start;
    logic                     tx_ready;
    logic                     busy;
    logic [7:0]               last_byte;  // Byte most recently handed to the UART
    logic                     msg_seen;   // Sticky, a message has completed

    cmd_message_rom u_rom (
        .msg_mode (msg_mode),
        .byte_idx (byte_idx),
        .msg_byte (msg_byte),
        .msg_len  (msg_len)
    );

    frame_sequencer #(
        .GAP_CYCLES (GAP_CYCLES)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .mode_sel (mode_sel),
        .msg_byte (msg_byte),
        .msg_len  (msg_len),
        .tx_ready (tx_ready),
        .msg_mode (msg_mode),
        .byte_idx (byte_idx),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .busy     (busy),
        .done     (done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_ready (tx_ready),
        .txd      (uart_txd)
    );

    // LED status registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_byte <= 8'h00;
            msg_seen  <= 1'b0;
        end else begin
            if (tx_start) begin
                last_byte <= tx_data;
            end
            if (done) begin
                msg_seen <= 1'b1;  // Cleared only by reset
            end
        end
    end

    // Bits 15..13 unused
    assign leds = {msg_seen, busy, 3'b000, byte_idx, last_byte};

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

`include "drive_cmd_macros.svh"

module uart_tx
    import drive_cmd_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DRV_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_ready,
    output logic       txd
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    tx_state_t         state;
    logic [CNT_W-1:0]  clk_cnt;   // Clocks into the current bit
    logic [2:0]        bit_cnt;   // Data bit on the line
    logic [7:0]        shreg;     // Data bits, LSB goes out first
    logic              bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // txd registered and set on each state change, clean pin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            txd     <= 1'b1;  // Line idles high
        end else begin
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        txd   <= 1'b0;  // Start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        txd     <= shreg[0];
                        state   <= TX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            txd   <= 1'b1;  // Stop bit
                            state <= TX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shreg[1];  // Next bit before the shift lands
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin  // TX_STOP
                    if (bit_end) begin
                        clk_cnt <= '0;
                        state   <= TX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Payload shifter
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= tx_data;
        end else if (state == TX_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    assign tx_ready = (state == TX_IDLE);

    a_line_level : assert property (@(posedge clk) disable iff (rst)
        ((state == TX_IDLE || state == TX_STOP) |-> txd) and
        ((state == TX_START) |-> !txd))
        else $error("txd level does not match frame state");

    // Ready held low for the whole frame, back one full frame after the strobe
    a_frame_len : assert property (@(posedge clk) disable iff (rst)
        $rose(tx_ready) |-> $past(tx_start, 10 * CLKS_PER_BIT + 1))
        else $error("tx_ready returned at the wrong time after a frame");

endmodule

/* src/frame_sequencer.sv */
`timescale 1ns/100ps

`include "drive_cmd_macros.svh"

module frame_sequencer
    import drive_cmd_pkg::*;
#(
    parameter int GAP_CYCLES = `DRV_GAP_CYCLES
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [2:0]               mode_sel,
    input  logic [7:0]               msg_byte,
    input  logic [`DRV_IDX_W-1:0]    msg_len,
    input  logic                     tx_ready,
    output drive_mode_t              msg_mode,
    output logic [`DRV_IDX_W-1:0]    byte_idx,
    output logic [7:0]               tx_data,
    output logic                     tx_start,
    output logic                     busy,
    output logic                     done
);

    localparam int GAP_W = (GAP_CYCLES > 0) ? $clog2(GAP_CYCLES + 1) : 1;

    seq_state_t        state;
    logic [GAP_W-1:0]  gap_cnt;
    drive_mode_t       mode_dec;  // Switch code as a drive mode

    // Spare codes 5..7 fall back to stop
    always_comb begin
        case (mode_sel)
            3'd1:    mode_dec = MODE_LEFT;
            3'd2:    mode_dec = MODE_RIGHT;
            3'd3:    mode_dec = MODE_FAST;
            3'd4:    mode_dec = MODE_SLOW;
            default: mode_dec = MODE_STOP;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SEQ_GAP;
            gap_cnt  <= '0;
            msg_mode <= MODE_STOP;
            byte_idx <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;  // Single-cycle strobe
            case (state)
                SEQ_GAP: begin
                    if (gap_cnt == GAP_W'(GAP_CYCLES)) begin
                        gap_cnt  <= '0;
                        msg_mode <= mode_dec;  // Held for the whole message
                        byte_idx <= '0;
                        state    <= SEQ_SEND;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                SEQ_SEND: begin
                    if (tx_ready) begin
                        tx_start <= 1'b1;
                        byte_idx <= byte_idx + 1'b1;
                        state    <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    // Ready is still high while the strobe is out
                    if (tx_ready && !tx_start) begin
                        state <= (byte_idx == msg_len) ? SEQ_END : SEQ_SEND;
                    end
                end
                default: begin  // SEQ_END
                    state <= SEQ_GAP;
                end
            endcase
        end
    end

    // Byte goes out with the strobe
    always_ff @(posedge clk) begin
        if (state == SEQ_SEND && tx_ready) begin
            tx_data <= msg_byte;
        end
    end

    assign busy = (state != SEQ_GAP);
    assign done = (state == SEQ_END);

    // Relies on the transmitter holding ready until it takes the byte
    a_start_ready : assert property (@(posedge clk) disable iff (rst)
        tx_start |-> tx_ready)
        else $error("tx_start raised while transmitter busy");

    a_done_pulse : assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done longer than one cycle");

    // No mode change once a message has started
    a_mode_hold : assert property (@(posedge clk) disable iff (rst)
        (state != SEQ_GAP && $past(state) != SEQ_GAP) |-> $stable(msg_mode))
        else $error("msg_mode changed inside a message");

endmodule

/* src/cmd_message_rom.sv */
`timescale 1ns/100ps

`include "drive_cmd_macros.svh"

module cmd_message_rom
    import drive_cmd_pkg::*;
(
    input  drive_mode_t              msg_mode,
    input  logic [`DRV_IDX_W-1:0]    byte_idx,
    output logic [7:0]               msg_byte,
    output logic [`DRV_IDX_W-1:0]    msg_len
);

    localparam int TXT_W = 8 * `DRV_MSG_MAX;

    // Command lines, byte 0 in the top byte
    // Shorter lines padded with newlines up to the full width
    // so any index past the end reads back as a newline
    // Minus sign is plain ASCII 2D here
    localparam logic [TXT_W-1:0] TXT_STOP  = {
        "{\"T\":1,\"L\":0,\"R\":0}", {8{8'h0A}}
    };
    localparam logic [TXT_W-1:0] TXT_LEFT  = {
        "{\"T\":1,\"L\":-0.25,\"R\":0.25}", 8'h0A
    };
    localparam logic [TXT_W-1:0] TXT_RIGHT = {
        "{\"T\":1,\"L\":0.25,\"R\":-0.25}", 8'h0A
    };
    localparam logic [TXT_W-1:0] TXT_FAST  = {
        "{\"T\":1,\"L\":0.5,\"R\":0.5}", {4{8'h0A}}
    };
    localparam logic [TXT_W-1:0] TXT_SLOW  = {
        "{\"T\":1,\"L\":0.25,\"R\":0.25}", {2{8'h0A}}
    };

    // Line lengths including the newline
    localparam logic [`DRV_IDX_W-1:0] LEN_STOP  = `DRV_IDX_W'(20);
    localparam logic [`DRV_IDX_W-1:0] LEN_LEFT  = `DRV_IDX_W'(27);
    localparam logic [`DRV_IDX_W-1:0] LEN_RIGHT = `DRV_IDX_W'(27);
    localparam logic [`DRV_IDX_W-1:0] LEN_FAST  = `DRV_IDX_W'(24);
    localparam logic [`DRV_IDX_W-1:0] LEN_SLOW  = `DRV_IDX_W'(26);

    logic [TXT_W-1:0] txt;  // Selected line

    // Byte idx counted from the top of the packed text
    function automatic logic [7:0] pick_byte(
        input logic [TXT_W-1:0]        line,
        input logic [`DRV_IDX_W-1:0]   idx
    );
        int pos;
        pos = `DRV_MSG_MAX - 1 - int'(idx);
        pick_byte = line[8*pos +: 8];
    endfunction

    always_comb begin
        txt     = TXT_STOP;
        msg_len = LEN_STOP;
        case (msg_mode)
            MODE_LEFT: begin
                txt     = TXT_LEFT;
                msg_len = LEN_LEFT;
            end
            MODE_RIGHT: begin
                txt     = TXT_RIGHT;
                msg_len = LEN_RIGHT;
            end
            MODE_FAST: begin
                txt     = TXT_FAST;
                msg_len = LEN_FAST;
            end
            MODE_SLOW: begin
                txt     = TXT_SLOW;
                msg_len = LEN_SLOW;
            end
            default: begin  // MODE_STOP
                txt     = TXT_STOP;
                msg_len = LEN_STOP;
            end
        endcase
    end

    // Indices 27..31 sit outside the table
    always_comb begin
        if (int'(byte_idx) < `DRV_MSG_MAX) begin
            msg_byte = pick_byte(txt, byte_idx);
        end else begin
            msg_byte = 8'h0A;
        end
    end

endmodule

/* src/drive_cmd_pkg.sv */
package drive_cmd_pkg;

    // Drive command, encoding matches the mode_sel switch codes
    typedef enum logic [2:0] {
        MODE_STOP  = 3'd0,
        MODE_LEFT  = 3'd1,
        MODE_RIGHT = 3'd2,
        MODE_FAST  = 3'd3,
        MODE_SLOW  = 3'd4
    } drive_mode_t;

    // Message sequencer FSM
    typedef enum logic [1:0] {
        SEQ_GAP,   // Idle gap, mode latched at its end
        SEQ_SEND,  // Hand next byte over
        SEQ_WAIT,  // Frame on the line
        SEQ_END    // Message complete
    } seq_state_t;

    // Serial transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

/* src/drive_cmd_macros.svh */
`ifndef DRIVE_CMD_MACROS_SVH
`define DRIVE_CMD_MACROS_SVH

// Board clock
`define DRV_CLK_FREQ_HZ 50_000_000

// Line rate of the robot controller link
`define DRV_BAUD_RATE 115_200

`define DRV_CLKS_PER_BIT (`DRV_CLK_FREQ_HZ / `DRV_BAUD_RATE)  // 434 clocks per bit

// Idle clocks before each message, none by default
`define DRV_GAP_CYCLES 0

// Longest command line, left and right turns
`define DRV_MSG_MAX 27
`define DRV_IDX_W $clog2(`DRV_MSG_MAX + 1)  // Byte index and length width, 5

`endif
